// File: common/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // Datapath width of the RV32I core
    localparam int unsigned XLEN = 32;

    // Plain data word as seen on the instruction bus
    typedef logic [XLEN-1:0] word_t;

    // Byte address of an instruction
    typedef logic [XLEN-1:0] addr_t;

    // Distance between two sequential instructions
    localparam addr_t PC_STEP = 32'd4;

    // Boot address, first fetch after reset
    localparam addr_t RESET_PC = 32'h8000_0000;

    // All-zero word replaces the instruction of a faulting fetch
    localparam word_t NOP_SQUASH = 32'h0000_0000;

    // Fetch to decode record, without its valid bit
    typedef struct packed {
        word_t instr;
        addr_t pc;
        addr_t pc4;
        // BTB hit steered the next PC
        logic  predicted;
        // Exception flags travel with the instruction
        logic  mal;
        logic  fault;
        // Faulting fetch address, zero without an exception
        addr_t badaddr;
    } fetch_rec_t;

endpackage

// File: common/btb_pkg.sv
package btb_pkg;

    // Direct-mapped, one target per entry
    localparam int unsigned BTB_ENTRIES = 16;
    localparam int unsigned BTB_INDEX_W = $clog2(BTB_ENTRIES);

    // Word offset bits sit below the index
    localparam int unsigned BTB_TAG_W = 32 - BTB_INDEX_W - 2;

    typedef logic [BTB_INDEX_W-1:0] btb_index_t;
    typedef logic [BTB_TAG_W-1:0]   btb_tag_t;

    // Entry index, PC bits 5 to 2
    function automatic btb_index_t btb_index(input logic [31:0] pc);
        return pc[BTB_INDEX_W+1:2];
    endfunction

    // Tag, remaining upper PC bits
    function automatic btb_tag_t btb_tag(input logic [31:0] pc);
        return pc[31:BTB_INDEX_W+2];
    endfunction

endpackage

// File: common/imem_req_if.sv
interface imem_req_if;
    import rv_fetch_pkg::*;

    // Request side, one outstanding fetch at a time
    logic  req;
    addr_t req_pc;

    // Cancels the outstanding fetch, no done follows
    logic  squash;

    // Response side, done strobes once per accepted req
    logic  done;
    word_t instr;
    logic  mal;
    logic  fault;

    modport fetch (
        output req, req_pc, squash,
        input  done, instr, mal, fault
    );

    modport bus (
        input  req, req_pc, squash,
        output done, instr, mal, fault
    );

endinterface

// File: common/predict_if.sv
interface predict_if;
    import rv_fetch_pkg::*;

    // Lookup, answered in the same cycle
    addr_t cur_pc;
    logic  hit;
    addr_t target;

    // Training from resolved branches
    logic  upd;
    addr_t upd_pc;
    addr_t upd_target;
    logic  upd_taken;

    modport fetch (
        output cur_pc, upd, upd_pc, upd_target, upd_taken,
        input  hit, target
    );

    modport btb (
        input  cur_pc, upd, upd_pc, upd_target, upd_taken,
        output hit, target
    );

endinterface

// File: src/imem_port.sv
module imem_port (
    input  logic                CLK,
    input  logic                nRST,
    imem_req_if.bus             im,
    output rv_fetch_pkg::addr_t imem_addr,
    output logic                imem_ren,
    input  rv_fetch_pkg::word_t imem_rdata,
    input  logic                imem_busy,
    input  logic                imem_error
);
    import rv_fetch_pkg::*;

    // READ holds ren until a non-busy cycle, DONE strobes the result
    typedef enum logic [1:0] {IDLE, READ, DONE} bus_state_t;

    bus_state_t state_q;
    logic       cancel_q;
    logic       pend_q;
    addr_t      addr_q;
    addr_t      pend_pc_q;
    word_t      instr_q;
    logic       mal_q;
    logic       fault_q;
    logic       take_req;
    logic       read_end;
    logic       read_drop;
    logic       launch;
    logic       launch_mal;
    addr_t      launch_pc;

    assign take_req  = im.req && !im.squash;
    assign read_end  = (state_q == READ) && !imem_busy;
    // Squashed read completes on the bus but is thrown away
    assign read_drop = read_end && (cancel_q || im.squash);

    // New fetch starts when the port is free
    always_comb begin
        launch    = 1'b0;
        launch_pc = im.req_pc;
        if (take_req && (state_q == IDLE || read_drop)) begin
            launch = 1'b1;
        end else if (pend_q && read_drop && !im.squash) begin
            // Request that arrived while a dropped read drained
            launch    = 1'b1;
            launch_pc = pend_pc_q;
        end
    end

    assign launch_mal = (launch_pc[1:0] != 2'b00);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q  <= IDLE;
            cancel_q <= 1'b0;
            pend_q   <= 1'b0;
        end else if (launch) begin
            // Misaligned address skips the bus entirely
            state_q  <= launch_mal ? DONE : READ;
            cancel_q <= 1'b0;
            pend_q   <= 1'b0;
        end else begin
            case (state_q)
                READ: begin
                    if (read_drop) begin
                        state_q  <= IDLE;
                        cancel_q <= 1'b0;
                        pend_q   <= 1'b0;
                    end else if (read_end) begin
                        state_q <= DONE;
                    end else if (im.squash) begin
                        cancel_q <= 1'b1;
                        pend_q   <= 1'b0;
                    end else if (take_req) begin
                        pend_q <= 1'b1;
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Address and response payload
    always_ff @(posedge CLK) begin
        if (launch) begin
            addr_q  <= launch_pc;
            mal_q   <= launch_mal;
            fault_q <= 1'b0;
            instr_q <= NOP_SQUASH;
        end else if (read_end && !read_drop) begin
            instr_q <= imem_rdata;
            fault_q <= imem_error;
            mal_q   <= 1'b0;
        end
        if (state_q == READ && take_req) begin
            pend_pc_q <= im.req_pc;
        end
    end

    assign imem_addr = addr_q;
    assign imem_ren  = (state_q == READ);

    assign im.done  = (state_q == DONE);
    assign im.instr = instr_q;
    assign im.mal   = mal_q;
    assign im.fault = fault_q;

    // Misaligned fetches never reach the bus
    a_aligned_read: assert property (@(posedge CLK) disable iff (!nRST)
        imem_ren |-> (imem_addr[1:0] == 2'b00));

endmodule

// File: src/predictor/branch_target_buffer.sv
module branch_target_buffer #(
    parameter int unsigned ENTRIES = btb_pkg::BTB_ENTRIES
) (
    input  logic  CLK,
    input  logic  nRST,
    predict_if.btb pd
);
    import rv_fetch_pkg::*;
    import btb_pkg::*;

    // Entry storage
    logic [ENTRIES-1:0] valid_q;
    btb_tag_t           tag_q    [ENTRIES];
    addr_t              target_q [ENTRIES];

    btb_index_t cur_idx;
    btb_tag_t   cur_tag;
    btb_index_t upd_idx;
    btb_tag_t   upd_tag;
    logic       upd_match;

    // Split lookup and training addresses
    assign cur_idx = btb_index(pd.cur_pc);
    assign cur_tag = btb_tag(pd.cur_pc);
    assign upd_idx = btb_index(pd.upd_pc);
    assign upd_tag = btb_tag(pd.upd_pc);

    // Combinational lookup
    assign pd.hit    = valid_q[cur_idx] && (tag_q[cur_idx] == cur_tag);
    assign pd.target = target_q[cur_idx];

    // Trained branch already owns its entry
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // Valid bits, the only state cleared by reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (pd.upd) begin
            if (pd.upd_taken) begin
                valid_q[upd_idx] <= 1'b1;
            end else if (upd_match) begin
                // Not taken, drop the stale prediction
                valid_q[upd_idx] <= 1'b0;
            end
        end
    end

    // Taken branch replaces whatever held the slot
    always_ff @(posedge CLK) begin
        if (pd.upd && pd.upd_taken) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= pd.upd_target;
        end
    end

    // Invalidated entry must not hit on the next lookup of that PC
    a_no_stale_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (pd.upd && !pd.upd_taken) ##1
        (cur_idx == $past(upd_idx) && cur_tag == $past(upd_tag))
        |-> !pd.hit);

endmodule

// File: src/fetch_stage/fetch_stage.sv
module fetch_stage (
    input  logic                CLK,
    input  logic                nRST,
    imem_req_if.fetch           im,
    predict_if.fetch            pd,
    input  logic                res_valid,
    input  rv_fetch_pkg::addr_t res_pc,
    input  logic                res_taken,
    input  rv_fetch_pkg::addr_t res_target,
    input  logic                res_mispredict,
    input  logic                stall,
    output logic                out_valid,
    output rv_fetch_pkg::word_t out_instr,
    output rv_fetch_pkg::addr_t out_pc,
    output rv_fetch_pkg::addr_t out_pc4,
    output logic                out_predicted,
    output logic                out_mal,
    output logic                out_fault,
    output rv_fetch_pkg::addr_t out_badaddr
);
    import rv_fetch_pkg::*;
    import btb_pkg::*;

    // ISSUE sends req, WAIT expects done, HELD keeps a result in the skid entry
    typedef enum logic [1:0] {ISSUE, WAIT, HELD} fetch_state_t;

    fetch_state_t state_q;
    addr_t        pc_q;
    addr_t        pc4;
    addr_t        npc;
    addr_t        redirect_pc;
    logic         redirect;
    logic         take_done;
    logic         exc;
    fetch_rec_t   new_rec;
    fetch_rec_t   skid_q;
    fetch_rec_t   out_q;

    // Mispredict from execute overrides everything
    assign redirect    = res_valid && res_mispredict;
    assign redirect_pc = res_taken ? res_target : res_pc + PC_STEP;

    // Sequential or predicted successor
    assign pc4 = pc_q + PC_STEP;
    assign npc = pd.hit ? pd.target : pc4;

    // Result of the live fetch, dropped under a redirect
    assign take_done = (state_q == WAIT) && im.done && !redirect;
    assign exc       = im.mal || im.fault;

    // Lookup on the PC being fetched
    assign pd.cur_pc = pc_q;

    // Every resolved branch trains the BTB
    assign pd.upd        = res_valid;
    assign pd.upd_pc     = res_pc;
    assign pd.upd_target = res_target;
    assign pd.upd_taken  = res_taken;

    assign im.req    = (state_q == ISSUE);
    assign im.req_pc = pc_q;
    assign im.squash = redirect;

    // Record for the fetch that just completed
    always_comb begin
        new_rec.instr     = exc ? NOP_SQUASH : im.instr;
        new_rec.pc        = pc_q;
        new_rec.pc4       = pc4;
        new_rec.predicted = pd.hit;
        new_rec.mal       = im.mal;
        new_rec.fault     = im.fault;
        new_rec.badaddr   = exc ? pc_q : '0;
    end

    // PC, FSM and record valid
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q   <= ISSUE;
            pc_q      <= RESET_PC;
            out_valid <= 1'b0;
        end else if (redirect) begin
            state_q   <= ISSUE;
            pc_q      <= redirect_pc;
            out_valid <= 1'b0;
        end else begin
            case (state_q)
                ISSUE: state_q <= WAIT;
                WAIT: begin
                    if (im.done) begin
                        // PC advances even if decode is stalled
                        pc_q    <= npc;
                        state_q <= stall ? HELD : ISSUE;
                    end
                end
                HELD: begin
                    if (!stall) begin
                        state_q <= ISSUE;
                    end
                end
                default: state_q <= ISSUE;
            endcase
            // Valid only drops when decode has taken the record
            if (!stall) begin
                out_valid <= take_done || (state_q == HELD);
            end
        end
    end

    // Output record and skid entry
    always_ff @(posedge CLK) begin
        if (redirect) begin
            out_q  <= '0;
            skid_q <= '0;
        end else begin
            if (take_done && stall) begin
                skid_q <= new_rec;
            end
            if (!stall) begin
                if (take_done) begin
                    out_q <= new_rec;
                end else if (state_q == HELD) begin
                    out_q <= skid_q;
                end
            end
        end
    end

    assign out_instr     = out_q.instr;
    assign out_pc        = out_q.pc;
    assign out_pc4       = out_q.pc4;
    assign out_predicted = out_q.predicted;
    assign out_mal       = out_q.mal;
    assign out_fault     = out_q.fault;
    assign out_badaddr   = out_q.badaddr;

    // No second req until the bus port answers or the fetch is squashed
    a_one_outstanding: assert property (@(posedge CLK) disable iff (!nRST)
        (im.req && !im.squash) |=> (!im.req until (im.done || im.squash)));

    // Taken branch trained at the current PC hits one cycle later
    a_trained_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (pd.upd && pd.upd_taken && btb_index(pd.upd_pc) == btb_index(pc_q) &&
         btb_tag(pd.upd_pc) == btb_tag(pc_q)) ##1 $stable(pc_q)
        |-> pd.hit && pd.target == $past(pd.upd_target));

endmodule

// File: src/fetch_unit.sv
module fetch_unit (
    input  logic                CLK,
    input  logic                nRST,
    // Instruction bus
    output rv_fetch_pkg::addr_t imem_addr,
    output logic                imem_ren,
    input  rv_fetch_pkg::word_t imem_rdata,
    input  logic                imem_busy,
    input  logic                imem_error,
    // Resolved branches from execute
    input  logic                res_valid,
    input  rv_fetch_pkg::addr_t res_pc,
    input  logic                res_taken,
    input  rv_fetch_pkg::addr_t res_target,
    input  logic                res_mispredict,
    // Decode back-pressure
    input  logic                stall,
    // Fetch to decode record
    output logic                out_valid,
    output rv_fetch_pkg::word_t out_instr,
    output rv_fetch_pkg::addr_t out_pc,
    output rv_fetch_pkg::addr_t out_pc4,
    output logic                out_predicted,
    output logic                out_mal,
    output logic                out_fault,
    output rv_fetch_pkg::addr_t out_badaddr
);
    import btb_pkg::*;

    // Stage to bus port handshake
    imem_req_if req_bus ();

    // Stage to BTB lookup and training
    predict_if  pred_bus ();

    fetch_stage i_fetch_stage (
        .CLK            (CLK),
        .nRST           (nRST),
        .im             (req_bus.fetch),
        .pd             (pred_bus.fetch),
        .res_valid      (res_valid),
        .res_pc         (res_pc),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .res_mispredict (res_mispredict),
        .stall          (stall),
        .out_valid      (out_valid),
        .out_instr      (out_instr),
        .out_pc         (out_pc),
        .out_pc4        (out_pc4),
        .out_predicted  (out_predicted),
        .out_mal        (out_mal),
        .out_fault      (out_fault),
        .out_badaddr    (out_badaddr)
    );

    branch_target_buffer #(
        .ENTRIES (BTB_ENTRIES)
    ) i_branch_target_buffer (
        .CLK  (CLK),
        .nRST (nRST),
        .pd   (pred_bus.btb)
    );

    imem_port i_imem_port (
        .CLK        (CLK),
        .nRST       (nRST),
        .im         (req_bus.bus),
        .imem_addr  (imem_addr),
        .imem_ren   (imem_ren),
        .imem_rdata (imem_rdata),
        .imem_busy  (imem_busy),
        .imem_error (imem_error)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock, low at time zero
    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) CLK = ~CLK;
        end
    end

    // Reset over the first edges, released just after an edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;
    end

endmodule

// File: bench/fetch_unit_tb.sv
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_fetch_pkg::*;

    // Bus model contents and error window
    localparam word_t DATA_KEY     = 32'h1357_9BDF;
    localparam addr_t ERR_LO       = 32'h8000_0100;
    localparam addr_t ERR_HI       = 32'h8000_01FF;
    localparam addr_t BOOT_PC      = 32'h8000_0000;
    localparam int    STEP_TIMEOUT = 400;

    // One table row: stall mask per cycle, optional mispredict, records to see
    typedef struct packed {
        logic [15:0] stall_mask;
        int          pre_stall;
        logic        do_res;
        addr_t       res_pc;
        logic        res_taken;
        addr_t       res_target;
        int          count;
    } step_t;

    logic  CLK;
    logic  nRST;
    addr_t imem_addr;
    logic  imem_ren;
    word_t imem_rdata;
    logic  imem_busy;
    logic  imem_error;
    logic  res_valid;
    addr_t res_pc;
    logic  res_taken;
    addr_t res_target;
    logic  res_mispredict;
    logic  stall;
    logic  out_valid;
    word_t out_instr;
    addr_t out_pc;
    addr_t out_pc4;
    logic  out_predicted;
    logic  out_mal;
    logic  out_fault;
    addr_t out_badaddr;

    // Reference BTB and next expected fetch address
    logic        mdl_valid  [16];
    logic [25:0] mdl_tag    [16];
    addr_t       mdl_target [16];
    addr_t       mdl_pc;

    // Bus model read tracking
    logic        read_open;
    int unsigned wait_left;

    // Previous sampled cycle, for the stall hold check
    logic  prev_stall;
    logic  prev_res;
    logic  prev_valid;
    addr_t prev_pc;
    word_t prev_instr;

    step_t step_q [$];
    string name_q [$];

    tb_clock i_clock (
        .CLK  (CLK),
        .nRST (nRST)
    );

    fetch_unit i_fetch_unit (.*);

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", what, exp, act);
            abort_run();
        end
    endtask

    function automatic logic in_error_window(input addr_t a);
        return (a >= ERR_LO) && (a <= ERR_HI);
    endfunction

    // BTB index is PC bits 5..2, tag the bits above
    function automatic logic model_hit(input addr_t pc);
        logic [3:0] idx;
        idx = pc[5:2];
        return mdl_valid[idx] && (mdl_tag[idx] == pc[31:6]);
    endfunction

    function automatic void train_model(input addr_t pc, input logic taken, input addr_t tgt);
        logic [3:0] idx;
        idx = pc[5:2];
        if (taken) begin
            mdl_valid[idx]  = 1'b1;
            mdl_tag[idx]    = pc[31:6];
            mdl_target[idx] = tgt;
        end else if (model_hit(pc)) begin
            mdl_valid[idx] = 1'b0;
        end
    endfunction

    // Bus model, random wait states, data is address XOR key
    initial begin
        void'($urandom(75));
        forever begin
            @(posedge CLK);
            #2;
            if (imem_ren && imem_addr[1:0] != 2'b00) begin
                $display("Instruction bus read issued at misaligned address %h", imem_addr);
                abort_run();
            end else if (imem_ren) begin
                if (!read_open) begin
                    read_open = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    imem_busy  = 1'b0;
                    imem_rdata = imem_addr ^ DATA_KEY;
                    imem_error = in_error_window(imem_addr);
                    read_open  = 1'b0;
                end else begin
                    imem_busy  = 1'b1;
                    imem_rdata = '0;
                    imem_error = 1'b0;
                    wait_left--;
                end
            end else begin
                imem_busy  = 1'b0;
                imem_rdata = '0;
                imem_error = 1'b0;
                read_open  = 1'b0;
            end
        end
    end

    task automatic add_step(input string name, input logic [15:0] mask, input int pre,
                            input logic do_res, input addr_t rpc, input logic taken,
                            input addr_t tgt, input int count);
        step_q.push_back(step_t'{mask, pre, do_res, rpc, taken, tgt, count});
        name_q.push_back(name);
    endtask

    task automatic load_table();
        //       name                 stall mask  pre res   res_pc         taken tgt    count
        add_step("boot_sequence",     16'h0000, 0, 1'b0, 32'h0,         1'b0, 32'h0,          6);
        add_step("stall_hold",        16'h3FF0, 0, 1'b0, 32'h0,         1'b0, 32'h0,          8);
        add_step("stall_toggle",      16'hAAAA, 0, 1'b0, 32'h0,         1'b0, 32'h0,          6);
        add_step("taken_redirect",    16'h0000, 0, 1'b1, 32'h8000_0238, 1'b1, 32'h8000_0300, 4);
        add_step("predicted_refetch", 16'h0C30, 0, 1'b1, 32'h8000_022C, 1'b0, 32'h8000_0A00, 5);
        add_step("untrain",           16'h0000, 0, 1'b1, 32'h8000_0238, 1'b0, 32'h8000_0A00, 2);
        add_step("plain_refetch",     16'h0000, 0, 1'b1, 32'h8000_0230, 1'b0, 32'h8000_0A00, 3);
        add_step("redirect_in_skid",  16'h0000, 5, 1'b1, 32'h8000_0600, 1'b1, 32'h8000_0080, 4);
        add_step("bus_error",         16'h0000, 0, 1'b1, 32'h8000_0400, 1'b1, 32'h8000_01F8, 4);
        add_step("misaligned",        16'h00F0, 0, 1'b1, 32'h8000_0500, 1'b1, 32'h8000_0302, 2);
        add_step("recover",           16'h5A5A, 0, 1'b1, 32'h8000_0000, 1'b0, 32'h8000_0A00, 6);
    endtask

    // One clock: drive after the edge, sample at the falling edge
    task automatic drive_cycle(input logic stall_val, input logic res_val, input step_t st,
                               input string name);
        @(posedge CLK);
        #2;
        stall          = stall_val;
        res_valid      = res_val;
        res_mispredict = res_val;
        res_pc         = st.res_pc;
        res_taken      = st.res_taken;
        res_target     = st.res_target;
        @(negedge CLK);
        // Stalled record holds unless a redirect cleared it
        if (prev_stall && !prev_res) begin
            check_flag($sformatf("%s hold valid", name), prev_valid, out_valid);
            check_addr($sformatf("%s hold pc", name), prev_pc, out_pc);
            check_word($sformatf("%s hold instr", name), prev_instr, out_instr);
        end
        prev_stall = stall_val;
        prev_res   = res_val;
        prev_valid = out_valid;
        prev_pc    = out_pc;
        prev_instr = out_instr;
    endtask

    // Record taken by decode, compared with the reference path
    task automatic expect_record(input string name, input int idx);
        addr_t pc;
        logic  mal;
        logic  fault;
        logic  hit;
        string tag;
        pc    = mdl_pc;
        mal   = (pc[1:0] != 2'b00);
        fault = !mal && in_error_window(pc);
        hit   = model_hit(pc);
        tag   = $sformatf("%s record %0d", name, idx);
        check_addr({tag, " pc"}, pc, out_pc);
        check_word({tag, " instr"}, (mal || fault) ? 32'h0 : (pc ^ DATA_KEY), out_instr);
        check_addr({tag, " pc4"}, pc + 32'd4, out_pc4);
        check_flag({tag, " predicted"}, hit, out_predicted);
        check_flag({tag, " mal"}, mal, out_mal);
        check_flag({tag, " fault"}, fault, out_fault);
        check_addr({tag, " badaddr"}, (mal || fault) ? pc : 32'h0, out_badaddr);
        mdl_pc = hit ? mdl_target[pc[5:2]] : pc + 32'd4;
    endtask

    task automatic apply_step(input step_t st, input string name);
        int         got;
        int         cyc;
        logic [3:0] phase;
        got = 0;
        cyc = 0;
        // Fill the skid entry before redirecting
        for (int k = 0; k < st.pre_stall; k++) begin
            drive_cycle(1'b1, 1'b0, st, name);
        end
        if (st.do_res) begin
            drive_cycle(st.pre_stall != 0, 1'b1, st, name);
            train_model(st.res_pc, st.res_taken, st.res_target);
            mdl_pc = st.res_taken ? st.res_target : st.res_pc + 32'd4;
        end
        while (got < st.count) begin
            if (cyc >= STEP_TIMEOUT) begin
                $display("Step %s saw only %0d of %0d records in %0d cycles",
                         name, got, st.count, cyc);
                abort_run();
            end else begin
                phase = cyc[3:0];
                drive_cycle(st.stall_mask[phase], 1'b0, st, name);
                cyc++;
                if (out_valid && !stall) begin
                    expect_record(name, got);
                    got++;
                end
            end
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!nRST) begin
            if (cycles > 10) begin
                $display("Reset was never released");
                abort_run();
            end else begin
                @(negedge CLK);
                check_flag("reset imem_ren", 1'b0, imem_ren);
                check_flag("reset out_valid", 1'b0, out_valid);
                cycles++;
            end
        end
    endtask

    initial begin
        stall          = 1'b0;
        res_valid      = 1'b0;
        res_mispredict = 1'b0;
        res_taken      = 1'b0;
        res_pc         = '0;
        res_target     = '0;
        imem_busy      = 1'b0;
        imem_rdata     = '0;
        imem_error     = 1'b0;
        read_open      = 1'b0;
        wait_left      = 0;
        prev_stall     = 1'b0;
        prev_res       = 1'b0;
        prev_valid     = 1'b0;
        prev_pc        = '0;
        prev_instr     = '0;
        for (int i = 0; i < 16; i++) begin
            mdl_valid[i] = 1'b0;
        end
        mdl_pc = BOOT_PC;
        load_table();
        wait_reset_release();
        for (int n = 0; n < step_q.size(); n++) begin
            apply_step(step_q[n], name_q[n]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: filelist.f
common/rv_fetch_pkg.sv
common/btb_pkg.sv
common/imem_req_if.sv
common/predict_if.sv
src/imem_port.sv
src/predictor/branch_target_buffer.sv
src/fetch_stage/fetch_stage.sv
src/fetch_unit.sv
bench/tb_clock.sv
bench/fetch_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fetch_unit_tb \
    -f filelist.f \
    --Mdir obj_dir -o fetch_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
